// File: verilog/pce_cart_pkg.sv
package pce_cart_pkg;

  // download byte counter, full ioctl address range
  localparam int cart_byte_addr_w = 24;

  // on-chip rom store, 32 KiB of bytes
  localparam int rom_addr_w = 15;

  typedef logic [rom_addr_w-1:0] rom_addr_t;
  typedef logic [7:0]            rom_byte_t;

  // size in 4 KiB pages, byte count bits 23..12
  typedef logic [11:0] rom_size_t;

  // copier header skipped on reads
  localparam rom_addr_t header_offset = 15'h200;

  // populous ranges, matched against byte count bits 23..4
  localparam logic [cart_byte_addr_w-5:0] pop_range_lo = 20'h1F2;
  localparam logic [cart_byte_addr_w-5:0] pop_range_hi = 20'h212;

  // signature words at offsets 6, 8, 10, 12
  localparam logic [15:0] pop_sig_0 = 16'h4F50;
  localparam logic [15:0] pop_sig_1 = 16'h5550;
  localparam logic [15:0] pop_sig_2 = 16'h4F4C;
  localparam logic [15:0] pop_sig_3 = 16'h5355;

  // word fifo between capture and byte writer
  localparam int fifo_depth = 4;

  // one downloaded word, addr is always even
  typedef struct packed {
    rom_addr_t   addr;
    logic [15:0] data;
  } rom_word_t;

  // cartridge status seen by the core
  typedef struct packed {
    rom_size_t size;
    logic      header;
    logic      pop;
    logic      done;
    logic      spare;
  } cart_info_t;

  typedef enum logic [1:0] {
    load_idle,
    load_busy,
    load_done
  } load_state_e;

endpackage

// File: verilog/cart_download.sv
`timescale 1ns/1ps

module cart_download import pce_cart_pkg::*; (
  input  logic        clk_sys_42_95,
  input  logic        reset,
  input  logic        cart_download,
  input  logic        ioctl_wr,
  input  logic        bit_reverse,
  input  logic [15:0] ioctl_dout,
  output logic        push,
  output rom_word_t   push_word,
  output cart_info_t  info
);

  logic                        dl_q;
  logic                        wr_q;
  logic                        dl_rise;
  logic                        dl_fall;
  logic                        wr_rise;
  logic                        wr_fall;
  load_state_e                 state;
  logic [cart_byte_addr_w-1:0] byte_cnt;
  logic [cart_byte_addr_w-1:0] cnt_nx;
  logic [15:0]                 dout_rev;
  logic [15:0]                 data_q;
  logic [1:0]                  pop_flags;
  logic [1:0]                  flags_nx;
  logic [15:0]                 sig_exp;
  logic                        sig_at;

  assign dl_rise = cart_download & ~dl_q;
  assign dl_fall = ~cart_download & dl_q;
  assign wr_rise = ioctl_wr & ~wr_q;
  assign wr_fall = ~ioctl_wr & wr_q;

  // swap bit order inside each byte
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      dout_rev[i]     = ioctl_dout[7-i];
      dout_rev[8 + i] = ioctl_dout[15-i];
    end
  end

  // captured word goes out with the address it was received at
  assign push_word.addr = byte_cnt[rom_addr_w-1:0];
  assign push_word.data = data_q;

  // address steps by two after the strobe drops
  always_comb begin
    cnt_nx = byte_cnt;
    if (wr_fall && state == load_busy) begin
      cnt_nx = byte_cnt + cart_byte_addr_w'(2);
    end
  end

  // signature compare on the word being pushed
  always_comb begin
    flags_nx = pop_flags;
    sig_exp  = pop_sig_0;
    sig_at   = 1'b1;
    case (byte_cnt[3:0])
      4'd6:    sig_exp = pop_sig_0;
      4'd8:    sig_exp = pop_sig_1;
      4'd10:   sig_exp = pop_sig_2;
      4'd12:   sig_exp = pop_sig_3;
      default: sig_at = 1'b0;
    endcase
    if (push && sig_at && data_q != sig_exp) begin
      // bit 0 plain image, bit 1 headered image
      if (byte_cnt[cart_byte_addr_w-1:4] == pop_range_lo) flags_nx[0] = 1'b0;
      if (byte_cnt[cart_byte_addr_w-1:4] == pop_range_hi) flags_nx[1] = 1'b0;
    end
  end

  // payload, latched at the strobe rising edge
  always_ff @(posedge clk_sys_42_95) begin
    if (wr_rise) begin
      data_q <= bit_reverse ? dout_rev : ioctl_dout;
    end
  end

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      dl_q      <= 1'b0;
      wr_q      <= 1'b0;
      state     <= load_idle;
      byte_cnt  <= '0;
      pop_flags <= 2'b00;
      push      <= 1'b0;
      info      <= '0;
    end else begin
      dl_q <= cart_download;
      wr_q <= ioctl_wr;
      push <= wr_rise && (state == load_busy);
      if (dl_rise) begin
        // new image, forget everything about the old one
        state     <= load_busy;
        byte_cnt  <= '0;
        pop_flags <= 2'b11;
        info      <= '0;
      end else begin
        byte_cnt  <= cnt_nx;
        pop_flags <= flags_nx;
        if (dl_fall && state == load_busy) begin
          state       <= load_done;
          info.size   <= cnt_nx[cart_byte_addr_w-1 -: $bits(rom_size_t)];
          // 512 byte copier header leaves bit 9 set
          info.header <= cnt_nx[9];
          info.pop    <= cnt_nx[9] ? flags_nx[1] : flags_nx[0];
          info.done   <= 1'b1;
        end
      end
    end
  end

endmodule

// File: verilog/cart_word_fifo.sv
`timescale 1ns/1ps

module cart_word_fifo import pce_cart_pkg::*; (
  input  logic      clk_sys_42_95,
  input  logic      reset,
  input  logic      push,
  input  logic      pop,
  input  rom_word_t push_word,
  output rom_word_t head,
  output logic      empty
);

  rom_word_t                       mem [fifo_depth];
  logic [$clog2(fifo_depth)-1:0]   wr_ptr;
  logic [$clog2(fifo_depth)-1:0]   rd_ptr;
  logic [$clog2(fifo_depth):0]     count;
  logic                            full;
  logic                            do_push;
  logic                            do_pop;

  assign empty = (count == '0);
  assign full  = (count == ($clog2(fifo_depth) + 1)'(fifo_depth));

  // a push into a full fifo is dropped
  assign do_push = push & ~full;
  assign do_pop  = pop & ~empty;

  // oldest entry is valid while not empty
  assign head = mem[rd_ptr];

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      for (int i = 0; i < fifo_depth; i++) begin
        mem[i] <= '0;
      end
    end else if (do_push) begin
      mem[wr_ptr] <= push_word;
    end
  end

  // pointers wrap on the power-of-two depth
  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // push and pop together leave the occupancy unchanged
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

// File: verilog/cart_rom.sv
`timescale 1ns/1ps

module cart_rom import pce_cart_pkg::*; (
  input  logic       clk_sys_42_95,
  input  logic       reset,
  input  rom_word_t  head,
  input  logic       empty,
  input  cart_info_t info,
  output logic       pop,
  input  logic       rom_rd,
  input  rom_addr_t  rom_addr,
  output rom_byte_t  rom_data,
  output logic       rom_rdy,
  output logic       loaded
);

  rom_byte_t mem [2**rom_addr_w];

  // high byte phase of the write sequencer
  logic      hi_phase;
  rom_addr_t hi_addr;
  rom_byte_t hi_data;
  rom_addr_t rd_addr;
  logic      rd_ok;

  // take a word only when the previous one is fully written
  assign pop = ~empty & ~hi_phase;

  // skip copier header when present
  assign rd_addr = rom_addr + (info.header ? header_offset : rom_addr_t'(0));

  // reads only after the store is complete
  assign rd_ok = rom_rd & loaded;

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      hi_phase <= 1'b0;
    end else if (pop) begin
      hi_phase <= 1'b1;
    end else begin
      hi_phase <= 1'b0;
    end
  end

  // upper half parked for the second write cycle
  always_ff @(posedge clk_sys_42_95) begin
    if (pop) begin
      hi_addr <= {head.addr[rom_addr_w-1:1], 1'b1};
      hi_data <= head.data[15:8];
    end
  end

  // little endian store, low byte at even address first
  always_ff @(posedge clk_sys_42_95) begin
    if (pop) begin
      mem[head.addr] <= head.data[7:0];
    end else if (hi_phase) begin
      mem[hi_addr] <= hi_data;
    end
  end

  // registered read port, one cycle latency
  always_ff @(posedge clk_sys_42_95) begin
    if (rd_ok) begin
      rom_data <= mem[rd_addr];
    end
  end

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      rom_rdy <= 1'b0;
      loaded  <= 1'b0;
    end else begin
      rom_rdy <= rd_ok;
      // download over, fifo drained and no byte write pending
      loaded  <= info.done & empty & ~hi_phase;
    end
  end

endmodule

// File: verilog/pce_cart_top.sv
`timescale 1ns/1ps

module pce_cart_top import pce_cart_pkg::*; (
  input  logic        clk_sys_42_95,
  input  logic        reset,
  input  logic        cart_download,
  input  logic        ioctl_wr,
  input  logic [15:0] ioctl_dout,
  input  logic        bit_reverse,
  input  logic        rom_rd,
  input  rom_addr_t   rom_addr,
  output rom_byte_t   rom_data,
  output logic        rom_rdy,
  output cart_info_t  info,
  output logic        loaded
);

  // capture to fifo
  logic      push;
  rom_word_t push_word;

  // fifo to byte writer
  logic      pop;
  logic      empty;
  rom_word_t head;

  cart_download u_download (
    .clk_sys_42_95 (clk_sys_42_95),
    .reset         (reset),
    .cart_download (cart_download),
    .ioctl_wr      (ioctl_wr),
    .bit_reverse   (bit_reverse),
    .ioctl_dout    (ioctl_dout),
    .push          (push),
    .push_word     (push_word),
    .info          (info)
  );

  cart_word_fifo u_fifo (
    .clk_sys_42_95 (clk_sys_42_95),
    .reset         (reset),
    .push          (push),
    .pop           (pop),
    .push_word     (push_word),
    .head          (head),
    .empty         (empty)
  );

  // info also steers the header offset and loaded
  cart_rom u_rom (
    .clk_sys_42_95 (clk_sys_42_95),
    .reset         (reset),
    .head          (head),
    .empty         (empty),
    .info          (info),
    .pop           (pop),
    .rom_rd        (rom_rd),
    .rom_addr      (rom_addr),
    .rom_data      (rom_data),
    .rom_rdy       (rom_rdy),
    .loaded        (loaded)
  );

endmodule

// File: verif/tb_pce_cart_ref.svh
`ifndef TB_PCE_CART_REF_SVH
`define TB_PCE_CART_REF_SVH

// mirror bits inside each byte, word byte order kept
function automatic logic [15:0] reverse_bits(input logic [15:0] w);
  logic [15:0] r;
  for (int i = 0; i < 16; i++) begin
    r[(i / 8) * 8 + 7 - (i % 8)] = w[i];
  end
  return r;
endfunction

// populous word k expected at range base + 6 + 2k
function automatic logic [15:0] sig_word(input int k);
  case (k)
    0:       return 16'h4F50;
    1:       return 16'h5550;
    2:       return 16'h4F4C;
    default: return 16'h5355;
  endcase
endfunction

// 4 KiB pages, byte count bits 23..12
function automatic rom_size_t expected_size(input int nbytes);
  return rom_size_t'(nbytes >> 12);
endfunction

// 512 byte copier header shows up as bit 9
function automatic logic expected_header(input int nbytes);
  return nbytes[9];
endfunction

// header images are read 0x200 further in
function automatic rom_byte_t expected_byte(input int addr, input logic hdr);
  int phys;
  phys = hdr ? addr + 512 : addr;
  return model_mem[phys % 32768];
endfunction

// flag of the range picked by the header, cleared on any loaded mismatch
function automatic logic expected_pop(input int nbytes);
  int          base;
  int          a;
  logic [15:0] w;
  base = expected_header(nbytes) ? 'h2120 : 'h1F20;
  for (int k = 0; k < 4; k++) begin
    a = base + 6 + 2 * k;
    if (a < nbytes) begin
      w = {model_mem[a + 1], model_mem[a]};
      if (w != sig_word(k)) begin
        return 1'b0;
      end
    end
  end
  return 1'b1;
endfunction

task automatic check_byte(input rom_byte_t got, input rom_byte_t exp);
  if (got !== exp) begin
    abort_run($sformatf("ERR %0t: rom_data %02h, expected %02h", $time, got, exp));
  end
endtask

task automatic check_info(input cart_info_t got, input cart_info_t exp);
  if (got !== exp) begin
    abort_run($sformatf("ERR %0t: info size %03h hdr %b pop %b done %b, expected %03h %b %b %b",
      $time, got.size, got.header, got.pop, got.done,
      exp.size, exp.header, exp.pop, exp.done));
  end
endtask

task automatic check_flag(input logic got, input logic exp, input string name);
  if (got !== exp) begin
    abort_run($sformatf("ERR %0t: %s is %b, expected %b", $time, name, got, exp));
  end
endtask

`endif

// File: verif/tb_pce_cart.sv
`timescale 1ns/1ps

module tb_pce_cart import pce_cart_pkg::*; ();

  // image sizes per case
  localparam int plain_words    = 1024;
  localparam int hdr_words      = 'h1100;
  localparam int nohdr_words    = 'h1000;
  localparam int redo_words     = 512;
  localparam int reads_per_case = 200;
  // every word downloaded over the whole run
  localparam int total_words    = 2 * plain_words + 3 * hdr_words + 2 * nohdr_words + redo_words;

  logic        clk_sys_42_95;
  logic        reset;
  logic        cart_download;
  logic        ioctl_wr;
  logic [15:0] ioctl_dout;
  logic        bit_reverse;
  logic        rom_rd;
  rom_addr_t   rom_addr;
  rom_byte_t   rom_data;
  logic        rom_rdy;
  cart_info_t  info;
  logic        loaded;

  // byte image as the rom should hold it
  rom_byte_t   model_mem [32768];
  // raw words of the next download as sent
  logic [15:0] raw_words [16384];
  // expected bytes of accepted reads in arrival order
  rom_byte_t   exp_q [$];
  // marks a read that must be answered
  logic        rd_tag;
  logic        rdy_due;
  int          errors;

  pce_cart_top dut (
    .clk_sys_42_95 (clk_sys_42_95),
    .reset         (reset),
    .cart_download (cart_download),
    .ioctl_wr      (ioctl_wr),
    .ioctl_dout    (ioctl_dout),
    .bit_reverse   (bit_reverse),
    .rom_rd        (rom_rd),
    .rom_addr      (rom_addr),
    .rom_data      (rom_data),
    .rom_rdy       (rom_rdy),
    .info          (info),
    .loaded        (loaded)
  );

  task automatic abort_run(input string line);
    errors++;
    $display("%s", line);
    $display("Finished with errors");
    $fatal(1, "run stopped at first error");
  endtask

  `include "tb_pce_cart_ref.svh"

  initial begin
    clk_sys_42_95 = 1'b0;
    forever #4 clk_sys_42_95 = ~clk_sys_42_95;
  end

  // budget of 10 cycles per word plus slack
  initial begin
    repeat (total_words * 10 + 2000) @(posedge clk_sys_42_95);
    abort_run("watchdog expired before all tests finished");
  end

  // rom_rdy and rom_data seen here were set at the previous edge
  always @(posedge clk_sys_42_95) begin
    if (reset) begin
      rdy_due = 1'b0;
    end else begin
      if (rom_rdy !== rdy_due) begin
        abort_run($sformatf("ERR %0t: rom_rdy %b, expected %b", $time, rom_rdy, rdy_due));
      end
      if (rom_rdy === 1'b1) begin
        check_byte(rom_data, exp_q.pop_front());
      end
      // read sampled at this edge answers at the next one
      rdy_due = rom_rd & rd_tag;
    end
  end

  task automatic fill_random(input int nwords);
    for (int i = 0; i < nwords; i++) begin
      raw_words[i] = 16'($urandom);
    end
  endtask

  // four words at byte offsets 6..12 of the range
  task automatic plant_signature(input int base);
    for (int k = 0; k < 4; k++) begin
      raw_words[(base + 6 + 2 * k) / 2] = sig_word(k);
    end
  endtask

  task automatic load_image(input int nwords, input logic rev);
    int          hi_len;
    int          lo_len;
    logic [15:0] w;
    bit_reverse   <= rev;
    cart_download <= 1'b1;
    // old image gone so size and pop read zero
    repeat (3) @(posedge clk_sys_42_95);
    check_flag(loaded, 1'b0, "loaded");
    check_info(info, '0);
    // a read during download gets no answer
    rom_rd   <= 1'b1;
    rom_addr <= rom_addr_t'($urandom);
    rd_tag   <= 1'b0;
    @(posedge clk_sys_42_95);
    rom_rd <= 1'b0;
    for (int i = 0; i < nwords; i++) begin
      hi_len = 1 + $urandom % 3;
      lo_len = 1 + $urandom % 3;
      ioctl_dout <= raw_words[i];
      ioctl_wr   <= 1'b1;
      repeat (hi_len) @(posedge clk_sys_42_95);
      ioctl_wr <= 1'b0;
      repeat (lo_len) @(posedge clk_sys_42_95);
    end
    cart_download <= 1'b0;
    // low byte at the even address
    for (int i = 0; i < nwords; i++) begin
      w = rev ? reverse_bits(raw_words[i]) : raw_words[i];
      model_mem[2 * i]     = w[7:0];
      model_mem[2 * i + 1] = w[15:8];
    end
  endtask

  task automatic wait_loaded();
    int n;
    n = 0;
    while (loaded !== 1'b1) begin
      @(posedge clk_sys_42_95);
      n++;
      if (n > 1000) begin
        abort_run("loaded did not rise after the download ended");
      end
    end
  endtask

  task automatic read_back(input int nbytes);
    logic hdr;
    int   span;
    int   addr;
    hdr  = expected_header(nbytes);
    span = hdr ? nbytes - 512 : nbytes;
    for (int i = 0; i < reads_per_case; i++) begin
      addr     = $urandom % span;
      rom_rd   <= 1'b1;
      rom_addr <= rom_addr_t'(addr);
      rd_tag   <= 1'b1;
      exp_q.push_back(expected_byte(addr, hdr));
      @(posedge clk_sys_42_95);
      // mostly back to back with an occasional gap
      if ($urandom % 4 == 0) begin
        rom_rd <= 1'b0;
        @(posedge clk_sys_42_95);
      end
    end
    rom_rd <= 1'b0;
    rd_tag <= 1'b0;
    repeat (3) @(posedge clk_sys_42_95);
    if (exp_q.size() != 0) begin
      abort_run("some reads got no rom_rdy response");
    end
  endtask

  task automatic run_case(input int nwords, input logic rev);
    cart_info_t exp;
    int         nbytes;
    nbytes = 2 * nwords;
    load_image(nwords, rev);
    wait_loaded();
    exp        = '0;
    exp.size   = expected_size(nbytes);
    exp.header = expected_header(nbytes);
    exp.pop    = expected_pop(nbytes);
    exp.done   = 1'b1;
    check_info(info, exp);
    read_back(nbytes);
  endtask

  initial begin
    void'($urandom(32'h5223_489f));
    errors        = 0;
    reset         = 1'b1;
    cart_download = 1'b0;
    ioctl_wr      = 1'b0;
    ioctl_dout    = '0;
    bit_reverse   = 1'b0;
    rom_rd        = 1'b0;
    rom_addr      = '0;
    rd_tag        = 1'b0;
    rdy_due       = 1'b0;
    repeat (8) @(posedge clk_sys_42_95);
    reset <= 1'b0;
    @(posedge clk_sys_42_95);
    check_flag(loaded, 1'b0, "loaded");
    check_info(info, '0);
    // plain image then the same size stored bit reversed
    fill_random(plain_words);
    run_case(plain_words, 1'b0);
    fill_random(plain_words);
    run_case(plain_words, 1'b1);
    // copier header present
    fill_random(hdr_words);
    run_case(hdr_words, 1'b0);
    check_flag(info.header, 1'b1, "info.header");
    // signature in the headered range then one word broken
    fill_random(hdr_words);
    plant_signature('h2120);
    run_case(hdr_words, 1'b0);
    check_flag(info.pop, 1'b1, "info.pop");
    raw_words[('h2120 + 10) / 2] ^= 16'h0100;
    run_case(hdr_words, 1'b0);
    check_flag(info.pop, 1'b0, "info.pop");
    // signature in the low range without a header
    fill_random(nohdr_words);
    plant_signature('h1F20);
    run_case(nohdr_words, 1'b0);
    check_flag(info.header, 1'b0, "info.header");
    check_flag(info.pop, 1'b1, "info.pop");
    // low range word broken while the high range is never reached
    raw_words[('h1F20 + 10) / 2] ^= 16'h0100;
    run_case(nohdr_words, 1'b0);
    check_flag(info.pop, 1'b0, "info.pop");
    // reload over a loaded image
    fill_random(redo_words);
    run_case(redo_words, 1'b0);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+verif
verilog/pce_cart_pkg.sv
verilog/cart_download.sv
verilog/cart_word_fifo.sv
verilog/cart_rom.sv
verilog/pce_cart_top.sv
verif/tb_pce_cart.sv

// File: Bender.yml
package:
  name: pce_cart

sources:
  - files:
      - verilog/pce_cart_pkg.sv
      - verilog/cart_download.sv
      - verilog/cart_word_fifo.sv
      - verilog/cart_rom.sv
      - verilog/pce_cart_top.sv
  - target: simulation
    include_dirs:
      - verif
    files:
      - verif/tb_pce_cart.sv
